/* logic/rv_core_pkg.sv */
package rv_core_pkg;

  localparam int REG_ADDR_W = 4; // RV32E has sixteen registers.
  localparam int NUM_REGS   = 16;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // encoded as {funct7[5], funct3}.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [1:0] {
    CTL_NONE,
    CTL_JUMP,
    CTL_BRANCH
  } ctl_kind_e;

  typedef struct packed {
    logic                  valid;
    logic [31:0]           pc;
    alu_op_e               alu_op;
    logic [31:0]           op1;
    logic [31:0]           op2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    ctl_kind_e             ctl;
    logic [2:0]            br_funct3;
    logic [31:0]           cmp_a;
    logic [31:0]           cmp_b;
    logic [31:0]           target; // jump or branch destination.
    logic                  illegal;
  } issue_t;

  typedef struct packed {
    logic                  valid;
    logic [31:0]           pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [31:0]           data;
    logic                  illegal;
  } commit_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

  function automatic logic [REG_ADDR_W-1:0] rd_of(input logic [31:0] inst);
    return inst[7 +: REG_ADDR_W];
  endfunction

  function automatic logic [REG_ADDR_W-1:0] rs1_of(input logic [31:0] inst);
    return inst[15 +: REG_ADDR_W];
  endfunction

  function automatic logic [REG_ADDR_W-1:0] rs2_of(input logic [31:0] inst);
    return inst[20 +: REG_ADDR_W];
  endfunction

  function automatic logic [31:0] imm_i(input logic [31:0] inst);
    return {{20{inst[31]}}, inst[31:20]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] inst);
    return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_u(input logic [31:0] inst);
    return {inst[31:12], 12'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] inst);
    return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

endpackage

/* logic/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  output logic [31:0]           rdata1_o,
  output logic [31:0]           rdata2_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [31:0]           wdata_i
);

  logic [31:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i; // x0 stays zero since it is never written.
    end
  end

  // reads see the old value during the cycle of a write.
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

/* logic/rv_busy_table.sv */
`timescale 1ns/10ps

module rv_busy_table import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  set_i,
  input  logic [REG_ADDR_W-1:0] set_rd_i,
  input  logic                  clr_i,
  input  logic [REG_ADDR_W-1:0] clr_rd_i,
  output logic [NUM_REGS-1:0]   busy_o
);

  logic [NUM_REGS-1:0] busy_q;
  logic [NUM_REGS-1:0] busy_d;

  always_comb begin
    busy_d = busy_q;
    if (clr_i) begin
      busy_d[clr_rd_i] = 1'b0; // the retiring write has reached the register file.
    end
    // a younger writer to the same register keeps it pending.
    if (set_i && (set_rd_i != '0)) begin
      busy_d[set_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  assign busy_o = busy_q;

endmodule

/* logic/rv_decode.sv */
`timescale 1ns/10ps

module rv_decode import rv_core_pkg::*; #(
  parameter bit FORWARD_EN = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  input  logic [31:0]           in_inst_i,
  input  logic [31:0]           in_pc_i,
  output logic                  in_ready_o,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  input  logic [31:0]           rdata1_i,
  input  logic [31:0]           rdata2_i,
  input  logic                  fwd_valid_i,
  input  logic [REG_ADDR_W-1:0] fwd_rd_i,
  input  logic [31:0]           fwd_data_i,
  input  logic [NUM_REGS-1:0]   busy_i,
  input  redirect_t             redirect_i,
  output issue_t                issue_o
);

  logic                  valid_q;
  logic [31:0]           inst_q;
  logic [31:0]           pc_q;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic                  fwd_hit1;
  logic                  fwd_hit2;
  logic [31:0]           rs1_val;
  logic [31:0]           rs2_val;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  stall;
  logic                  issue_fire;
  logic                  accept;

  assign opcode = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rs1    = rs1_of(inst_q);
  assign rs2    = rs2_of(inst_q);
  assign rd     = rd_of(inst_q);
  assign rs1_o  = rs1;
  assign rs2_o  = rs2;

  // the instruction in execute is younger than anything in writeback, so it takes priority.
  assign fwd_hit1 = FORWARD_EN && fwd_valid_i && (fwd_rd_i == rs1) && (rs1 != '0);
  assign fwd_hit2 = FORWARD_EN && fwd_valid_i && (fwd_rd_i == rs2) && (rs2 != '0);
  assign rs1_val  = fwd_hit1 ? fwd_data_i : rdata1_i;
  assign rs2_val  = fwd_hit2 ? fwd_data_i : rdata2_i;

  always_comb begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_JALR, OPC_OP_IMM: use_rs1 = 1'b1;
      OPC_BRANCH, OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      default: ; // U-type, JAL and illegal opcodes read no register.
    endcase
  end

  assign stall = valid_q && ((use_rs1 && busy_i[rs1] && !fwd_hit1) ||
                             (use_rs2 && busy_i[rs2] && !fwd_hit2));

  assign issue_fire = valid_q && !stall;
  assign in_ready_o = (!valid_q || !stall) && !redirect_i.valid;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (redirect_i.valid) begin
      valid_q <= 1'b0; // wrong-path instruction is dropped.
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (issue_fire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= in_inst_i;
      pc_q   <= in_pc_i;
    end
  end

  always_comb begin
    issue_o           = '0;
    issue_o.valid     = issue_fire;
    issue_o.pc        = pc_q;
    issue_o.alu_op    = ALU_ADD;
    issue_o.rd        = rd;
    issue_o.ctl       = CTL_NONE;
    issue_o.br_funct3 = funct3;
    issue_o.cmp_a     = rs1_val;
    issue_o.cmp_b     = rs2_val;
    case (opcode)
      OPC_LUI: begin
        issue_o.op2   = imm_u(inst_q);
        issue_o.rd_we = 1'b1;
      end
      OPC_AUIPC: begin
        issue_o.op1   = pc_q;
        issue_o.op2   = imm_u(inst_q);
        issue_o.rd_we = 1'b1;
      end
      OPC_JAL: begin
        issue_o.op1    = pc_q; // link value is pc plus 4.
        issue_o.op2    = 32'd4;
        issue_o.rd_we  = 1'b1;
        issue_o.ctl    = CTL_JUMP;
        issue_o.target = pc_q + imm_j(inst_q);
      end
      OPC_JALR: begin
        issue_o.op1    = pc_q;
        issue_o.op2    = 32'd4;
        issue_o.rd_we  = 1'b1;
        issue_o.ctl    = CTL_JUMP;
        issue_o.target = (rs1_val + imm_i(inst_q)) & ~32'd1;
      end
      OPC_BRANCH: begin
        issue_o.ctl     = CTL_BRANCH;
        issue_o.target  = pc_q + imm_b(inst_q);
        issue_o.illegal = (funct3[2:1] == 2'b01); // funct3 010 and 011 are unassigned.
      end
      OPC_OP_IMM: begin
        issue_o.op1    = rs1_val;
        issue_o.op2    = imm_i(inst_q);
        issue_o.alu_op = alu_op_e'({(funct3 == 3'b101) && funct7[5], funct3});
        issue_o.rd_we  = 1'b1;
      end
      OPC_OP: begin
        issue_o.op1     = rs1_val;
        issue_o.op2     = rs2_val;
        issue_o.alu_op  = alu_op_e'({funct7[5], funct3});
        issue_o.illegal = funct7[5] && (funct3 != 3'b000) && (funct3 != 3'b101);
        issue_o.rd_we   = !issue_o.illegal;
      end
      default: issue_o.illegal = 1'b1;
    endcase
    issue_o.rd_we = issue_o.rd_we && (rd != '0); // x0 never gets a pending write.
  end

endmodule

/* logic/rv_execute.sv */
`timescale 1ns/10ps

module rv_execute import rv_core_pkg::*; #(
  parameter bit FORWARD_EN = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  issue_t                issue_i,
  output logic                  fwd_valid_o,
  output logic [REG_ADDR_W-1:0] fwd_rd_o,
  output logic [31:0]           fwd_data_o,
  output logic                  busy_set_o,
  output logic [REG_ADDR_W-1:0] busy_set_rd_o,
  output logic                  busy_clr_o,
  output logic [REG_ADDR_W-1:0] busy_clr_rd_o,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [31:0]           rf_wdata_o,
  output commit_t               commit_o,
  output redirect_t             redirect_o
);

  issue_t      ex_q;
  commit_t     wb_q;
  logic        wb_taken;
  logic [31:0] wb_target;
  logic        wb_sq;
  logic [31:0] alu_res;
  logic        br_cond;
  logic        taken;
  logic        flush;
  logic        ex_wr;
  logic        wb_wr;
  logic        keep_busy;

  assign flush = redirect_o.valid;

  always_comb begin
    case (ex_q.alu_op)
      ALU_ADD:  alu_res = ex_q.op1 + ex_q.op2;
      ALU_SUB:  alu_res = ex_q.op1 - ex_q.op2;
      ALU_SLL:  alu_res = ex_q.op1 << ex_q.op2[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(ex_q.op1) < $signed(ex_q.op2)};
      ALU_SLTU: alu_res = {31'b0, ex_q.op1 < ex_q.op2};
      ALU_XOR:  alu_res = ex_q.op1 ^ ex_q.op2;
      ALU_SRL:  alu_res = ex_q.op1 >> ex_q.op2[4:0];
      ALU_SRA:  alu_res = $signed(ex_q.op1) >>> ex_q.op2[4:0];
      ALU_OR:   alu_res = ex_q.op1 | ex_q.op2;
      ALU_AND:  alu_res = ex_q.op1 & ex_q.op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (ex_q.br_funct3)
      3'b000:  br_cond = ex_q.cmp_a == ex_q.cmp_b;
      3'b001:  br_cond = ex_q.cmp_a != ex_q.cmp_b;
      3'b100:  br_cond = $signed(ex_q.cmp_a) < $signed(ex_q.cmp_b);
      3'b101:  br_cond = $signed(ex_q.cmp_a) >= $signed(ex_q.cmp_b);
      3'b110:  br_cond = ex_q.cmp_a < ex_q.cmp_b;
      3'b111:  br_cond = ex_q.cmp_a >= ex_q.cmp_b;
      default: br_cond = 1'b0;
    endcase
  end

  assign taken = (ex_q.ctl == CTL_JUMP) || ((ex_q.ctl == CTL_BRANCH) && br_cond);

  assign ex_wr = ex_q.valid && ex_q.rd_we;
  assign wb_wr = wb_q.valid && wb_q.rd_we;

  // a live writer in execute with the same rd still owns the pending bit.
  assign keep_busy = ex_wr && !flush && (ex_q.rd == wb_q.rd);

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_q.valid <= 1'b0;
      wb_q.valid <= 1'b0;
      wb_sq      <= 1'b0;
    end else begin
      ex_q         <= issue_i;
      ex_q.valid   <= issue_i.valid && !flush;
      wb_q.valid   <= ex_q.valid && !flush; // squash the instruction behind a taken jump.
      wb_q.pc      <= ex_q.pc;
      wb_q.rd      <= ex_q.rd;
      wb_q.rd_we   <= ex_q.rd_we;
      wb_q.data    <= alu_res;
      wb_q.illegal <= ex_q.illegal;
      wb_taken     <= taken;
      wb_target    <= ex_q.target;
      wb_sq        <= !FORWARD_EN && ex_wr && flush;
    end
  end

  assign fwd_valid_o = ex_wr;
  assign fwd_rd_o    = ex_q.rd;
  assign fwd_data_o  = alu_res;

  // without forwarding, destinations are marked as soon as they issue.
  assign busy_set_o    = FORWARD_EN ? (ex_wr && !flush) :
                                      (issue_i.valid && issue_i.rd_we && !flush);
  assign busy_set_rd_o = FORWARD_EN ? ex_q.rd : issue_i.rd;
  assign busy_clr_o    = (wb_wr && !keep_busy) || wb_sq; // wb_sq releases a squashed rd.
  assign busy_clr_rd_o = wb_q.rd;

  assign rf_we_o    = wb_wr;
  assign rf_waddr_o = wb_q.rd;
  assign rf_wdata_o = wb_q.data;

  assign commit_o   = wb_q;
  assign redirect_o = '{valid: wb_q.valid && wb_taken, pc: wb_target};

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/10ps

module rv_core_top import rv_core_pkg::*; #(
  parameter bit FORWARD_EN = 1'b1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  input  logic [31:0] in_inst_i,
  input  logic [31:0] in_pc_i,
  output logic        in_ready_o,
  output commit_t     commit_o,
  output redirect_t   redirect_o
);

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [31:0]           rdata1;
  logic [31:0]           rdata2;
  logic                  fwd_valid;
  logic [REG_ADDR_W-1:0] fwd_rd;
  logic [31:0]           fwd_data;
  logic [NUM_REGS-1:0]   busy;
  issue_t                issue;
  logic                  busy_set;
  logic [REG_ADDR_W-1:0] busy_set_rd;
  logic                  busy_clr;
  logic [REG_ADDR_W-1:0] busy_clr_rd;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [31:0]           rf_wdata;

  rv_decode #(
    .FORWARD_EN (FORWARD_EN)
  ) u_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_inst_i   (in_inst_i),
    .in_pc_i     (in_pc_i),
    .in_ready_o  (in_ready_o),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .fwd_valid_i (fwd_valid),
    .fwd_rd_i    (fwd_rd),
    .fwd_data_i  (fwd_data),
    .busy_i      (busy),
    .redirect_i  (redirect_o),
    .issue_o     (issue)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  rv_busy_table u_busy_table (
    .clk      (clk),
    .rst      (rst),
    .set_i    (busy_set),
    .set_rd_i (busy_set_rd),
    .clr_i    (busy_clr),
    .clr_rd_i (busy_clr_rd),
    .busy_o   (busy)
  );

  rv_execute #(
    .FORWARD_EN (FORWARD_EN)
  ) u_execute (
    .clk           (clk),
    .rst           (rst),
    .issue_i       (issue),
    .fwd_valid_o   (fwd_valid),
    .fwd_rd_o      (fwd_rd),
    .fwd_data_o    (fwd_data),
    .busy_set_o    (busy_set),
    .busy_set_rd_o (busy_set_rd),
    .busy_clr_o    (busy_clr),
    .busy_clr_rd_o (busy_clr_rd),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .commit_o      (commit_o),
    .redirect_o    (redirect_o)
  );

endmodule

/* sim/rv_core_assertions.sv */
`timescale 1ns/10ps

module rv_core_assertions import rv_core_pkg::*; (
  input logic                  clk,
  input logic                  rst,
  input logic                  in_ready_o,
  input logic                  valid_q,
  input logic [31:0]           inst_q,
  input logic [NUM_REGS-1:0]   busy_i,
  input logic                  fwd_valid_i,
  input logic [REG_ADDR_W-1:0] fwd_rd_i,
  input logic [REG_ADDR_W-1:0] rs1_o,
  input logic [REG_ADDR_W-1:0] rs2_o,
  input redirect_t             redirect_i,
  input issue_t                issue_o
);

  int unsigned errors = 0;
  logic [6:0]  opc;
  logic        reads1;
  logic        reads2;
  logic        hit1;
  logic        hit2;
  logic        hazard;
  logic        fwd_only;
  logic        pending;
  logic [31:0] pend_pc;

  assign opc    = inst_q[6:0];
  assign reads1 = opc inside {7'b1100111, 7'b0010011, 7'b1100011, 7'b0110011};
  assign reads2 = opc inside {7'b1100011, 7'b0110011};
  assign hit1   = fwd_valid_i && (fwd_rd_i == rs1_o) && (rs1_o != '0);
  assign hit2   = fwd_valid_i && (fwd_rd_i == rs2_o) && (rs2_o != '0);
  assign hazard = valid_q && ((reads1 && busy_i[rs1_o] && !hit1) ||
                              (reads2 && busy_i[rs2_o] && !hit2));
  assign fwd_only = valid_q && (hit1 || hit2) && !hazard && !redirect_i.valid;

  // remembers where the last redirect pointed until the next issue.
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (redirect_i.valid) begin
      pending <= 1'b1;
      pend_pc <= redirect_i.pc;
    end else if (issue_o.valid) begin
      pending <= 1'b0;
    end
  end

  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> in_ready_o && !redirect_i.valid)
    else begin
      $error("core not idle after reset");
      errors++;
    end

  a_forward_no_stall: assert property (@(posedge clk) disable iff (rst) fwd_only |-> in_ready_o)
    else begin
      $error("forwarded operand caused a stall");
      errors++;
    end

  a_hazard_stall: assert property (@(posedge clk) disable iff (rst)
    hazard |-> !in_ready_o && !issue_o.valid)
    else begin
      $error("busy source register did not stall decode");
      errors++;
    end

  a_redirect_target: assert property (@(posedge clk) disable iff (rst)
    pending && issue_o.valid |-> issue_o.pc == pend_pc)
    else begin
      $error("first issue after redirect is not at the target");
      errors++;
    end

endmodule

/* sim/rv_core_tb.sv */
`timescale 1ns/10ps

module rv_core_tb import rv_core_pkg::*; ();

  localparam int          PROG_WORDS = 32;
  localparam logic [31:0] LAST_PC    = 32'd120;
  localparam int          MAX_CYCLES = 2000;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic [31:0] in_inst_i;
  logic [31:0] in_pc_i;
  logic        in_ready_o;
  commit_t     commit_o;
  redirect_t   redirect_o;
  logic [31:0] prog [PROG_WORDS];
  logic [31:0] fetch_pc;
  logic [31:0] model_regs [16];
  logic [31:0] model_pc;
  logic        done;
  int          cycles;
  logic        idle_slot [MAX_CYCLES];
  int          gap_idx;

  rv_core_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .in_inst_i  (in_inst_i),
    .in_pc_i    (in_pc_i),
    .in_ready_o (in_ready_o),
    .commit_o   (commit_o),
    .redirect_o (redirect_o)
  );

  bind rv_decode rv_core_assertions u_assert (
    .clk         (clk),
    .rst         (rst),
    .in_ready_o  (in_ready_o),
    .valid_q     (valid_q),
    .inst_q      (inst_q),
    .busy_i      (busy_i),
    .fwd_valid_i (fwd_valid_i),
    .fwd_rd_i    (fwd_rd_i),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .redirect_i  (redirect_i),
    .issue_o     (issue_o)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                        input int rd, input logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    logic [12:0] o;
    o = 13'(imm);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, input int rd);
    logic [20:0] o;
    o = 21'(imm);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt) begin
          return $signed(x) >>> y[4:0]; // sign bit fills from the left.
        end else begin
          return x >> y[4:0];
        end
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic fail_stop();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = enc_i(99, 0, 3'b000, 12, OPC_OP_IMM); // wrong-path filler.
    end
    prog[0]  = enc_i(5, 0, 3'b000, 1, OPC_OP_IMM);
    prog[1]  = enc_i(-12, 1, 3'b000, 2, OPC_OP_IMM);
    prog[2]  = enc_r(7'b0100000, 1, 2, 3'b000, 3);
    prog[3]  = enc_r(7'b0100000, 1, 2, 3'b101, 4);
    prog[4]  = enc_r(7'b0000000, 2, 1, 3'b011, 5);
    prog[5]  = {20'h12345, 5'd6, OPC_LUI};
    prog[6]  = {20'h00001, 5'd7, OPC_AUIPC};
    prog[7]  = enc_r(7'b0000000, 1, 6, 3'b100, 8);
    prog[8]  = enc_r(7'b0000000, 6, 8, 3'b000, 9);
    prog[9]  = enc_r(7'b0000000, 1, 8, 3'b000, 10); // x8 is two ahead and sits in writeback.
    prog[10] = enc_i(7, 1, 3'b000, 0, OPC_OP_IMM);
    prog[11] = enc_r(7'b0000000, 1, 0, 3'b000, 11);
    prog[12] = enc_b(8, 1, 1, 3'b000);
    prog[14] = enc_b(8, 1, 1, 3'b001);
    prog[15] = enc_b(8, 1, 2, 3'b100);
    prog[17] = enc_b(8, 1, 2, 3'b101);
    prog[18] = enc_b(8, 1, 2, 3'b110);
    prog[19] = enc_b(8, 1, 2, 3'b111);
    prog[21] = enc_j(8, 13);
    prog[23] = enc_i(104, 0, 3'b000, 14, OPC_OP_IMM);
    prog[24] = enc_i(0, 14, 3'b000, 15, OPC_JALR);
    prog[26] = enc_i(0, 1, 3'b010, 12, 7'b0000011); // load opcode is not supported.
    prog[27] = enc_r(7'b0000000, 1, 2, 3'b010, 12);
    prog[28] = enc_i(1025, 2, 3'b101, 14, OPC_OP_IMM);
    prog[29] = enc_r(7'b0000000, 13, 12, 3'b110, 15);
    prog[30] = enc_r(7'b0000000, 3, 15, 3'b111, 1);
  endtask

  // in-order model of one instruction, then compare with the commit.
  task automatic check_commit();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immi;
    logic [31:0] data;
    logic [31:0] npc;
    logic        we;
    logic        ill;
    logic        cond;
    inst = prog[model_pc[6:2]];
    a    = model_regs[inst[18:15]];
    b    = model_regs[inst[23:20]];
    immi = {{20{inst[31]}}, inst[31:20]};
    npc  = model_pc + 32'd4;
    data = '0;
    we   = 1'b1;
    ill  = 1'b0;
    check_value("commit pc", model_pc, commit_o.pc);
    case (inst[6:0])
      OPC_LUI:    data = {inst[31:12], 12'b0};
      OPC_AUIPC:  data = model_pc + {inst[31:12], 12'b0};
      OPC_JAL: begin
        data = model_pc + 32'd4;
        npc  = model_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        data = model_pc + 32'd4;
        npc  = (a + immi) & ~32'd1;
      end
      OPC_BRANCH: begin
        we = 1'b0;
        case (inst[14:12])
          3'b000:  cond = a == b;
          3'b001:  cond = a != b;
          3'b100:  cond = $signed(a) < $signed(b);
          3'b101:  cond = $signed(a) >= $signed(b);
          3'b110:  cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond) begin
          npc = model_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      OPC_OP_IMM: data = alu_ref(inst[14:12], (inst[14:12] == 3'b101) && inst[30], a, immi);
      OPC_OP:     data = alu_ref(inst[14:12], inst[30], a, b);
      default: begin
        we  = 1'b0;
        ill = 1'b1;
      end
    endcase
    we = we && (inst[10:7] != 4'd0);
    check_value("illegal flag", ill, commit_o.illegal);
    check_value("write enable", we, commit_o.rd_we);
    if (we) begin
      check_value("commit rd", inst[10:7], commit_o.rd);
      check_value("commit data", data, commit_o.data);
      model_regs[inst[10:7]] = data;
    end
    check_value("redirect valid", npc != model_pc + 32'd4, redirect_o.valid);
    if (redirect_o.valid) begin
      check_value("redirect pc", npc, redirect_o.pc);
    end
    if (model_pc == LAST_PC) begin
      done = 1'b1;
    end
    model_pc = npc;
  endtask

  always @(posedge clk) begin
    if (dut0.u_decode.u_assert.errors != 0) begin
      $display("a bound assertion on the decode stage failed");
      fail_stop();
    end
    if (!rst && commit_o.valid) begin
      check_commit();
    end
  end

  // testbench fetch with random idle cycles.
  always @(posedge clk) begin : fetch
    logic [31:0] next_pc;
    logic        hold;
    next_pc = fetch_pc;
    hold    = in_valid_i && !in_ready_o;
    if (in_valid_i && in_ready_o) begin
      next_pc = fetch_pc + 32'd4;
    end
    if (rst) begin
      next_pc = '0;
      hold    = 1'b0;
    end else if (redirect_o.valid) begin
      next_pc = redirect_o.pc;
      hold    = 1'b0;
    end
    fetch_pc <= next_pc;
    if (!hold) begin
      in_valid_i <= !rst && (next_pc <= LAST_PC) && !idle_slot[gap_idx % MAX_CYCLES];
      in_inst_i  <= prog[next_pc[6:2]];
      in_pc_i    <= next_pc;
      gap_idx    = gap_idx + 1;
    end
  end

  initial begin
    void'($urandom(85282));
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid_i = 1'b0;
    in_inst_i  = '0;
    in_pc_i    = '0;
    fetch_pc   = '0;
    model_pc   = '0;
    done       = 1'b0;
    cycles     = 0;
    gap_idx    = 0;
    for (int i = 0; i < MAX_CYCLES; i++) begin
      idle_slot[i] = ($urandom_range(3) == 0); // about one slot in four stays idle.
    end
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = '0;
    end
    load_program();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("reset ready", 1'b1, in_ready_o);
    check_value("reset commit valid", 1'b0, commit_o.valid);
    while (!done && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout waiting for the last instruction to commit");
      fail_stop();
    end
    repeat (2) @(posedge clk);
    if (dut0.u_decode.u_assert.errors != 0) begin
      fail_stop();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* sim.f */
logic/rv_core_pkg.sv
logic/rv_regfile.sv
logic/rv_busy_table.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_core_top.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv
